/* hw/kd_pkg.sv */
// Tree depth and patch geometry are fixed here at compile time; changing kd_depth also needs kd_nodes/kd_leaves updated
package kd_pkg;

  // Tree geometry
  localparam int unsigned kd_depth  = 4;   // Internal levels, root is level 0
  localparam int unsigned kd_nodes  = 15;  // 2**kd_depth - 1 internal nodes
  localparam int unsigned kd_leaves = 16;  // 2**kd_depth leaves
  localparam int unsigned kd_dims   = 5;   // Components per patch
  localparam int unsigned kd_comp_w = 11;  // Bits per component

  // Field widths
  localparam int unsigned kd_dim_w  = 3;   // Holds 0..7, values above kd_dims-1 fold to 0
  localparam int unsigned kd_leaf_w = 4;   // Leaf index 0..15
  localparam int unsigned kd_tag_w  = 4;   // Host query tag
  localparam int unsigned kd_cnt_w  = 4;   // Write counter, saturates at kd_nodes

  // One patch, component 0 in the low bits
  typedef logic [kd_dims-1:0][kd_comp_w-1:0] patch_t;

  // Internal node word as written by the host
  typedef struct packed {
    logic [kd_dim_w-1:0]  dim;     // Split dimension
    logic [kd_comp_w-1:0] median;  // Split value, equal goes right
  } node_t;

  // Query side scalars
  typedef logic [kd_tag_w-1:0]  tag_t;
  typedef logic [kd_leaf_w-1:0] leaf_t;

endpackage

/* hw/kd_cfg_if.sv */
// Node load bus; sel is one-hot or zero, wr is only meaningful while loading is high
`timescale 1ns/1ns

interface kd_cfg_if;

  logic                        wr;       // Write strobe, already qualified by load_en
  logic [kd_pkg::kd_nodes-1:0] sel;      // One-hot target node
  kd_pkg::node_t               data;     // Node word, shared by all nodes
  logic                        loading;  // Load session active

  // Counter side drives the bus
  modport writer (
    output wr,
    output sel,
    output data,
    output loading
  );

  // Tree side only listens
  modport tree (
    input wr,
    input sel,
    input data,
    input loading
  );

endinterface

/* hw/kd_node_writer.sv */
// Breadth-first node loader; count restarts whenever load_en drops and writes past node 14 are dropped
`timescale 1ns/1ns

module kd_node_writer (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          load_en,    // Level, high for a whole load session
  input  logic          node_wr,    // One node word per high cycle
  input  kd_pkg::node_t node_data,
  kd_cfg_if.writer      cfg
);

  logic [kd_pkg::kd_cnt_w-1:0] wr_cnt;  // Index of the next node to write
  logic                        room;    // Counter still points at a real node
  logic                        wr_ok;   // Write accepted this cycle

  assign room  = (wr_cnt < kd_pkg::kd_nodes);
  assign wr_ok = load_en & node_wr & room;

  // Address counter
  // Cleared between sessions so a reload starts again at the root
  always_ff @(posedge clk) begin
    if (!rst_n || !load_en) begin
      wr_cnt <= '0;
    end else if (wr_ok) begin
      wr_cnt <= wr_cnt + kd_pkg::kd_cnt_w'(1);  // Stops at kd_nodes, room goes low
    end
  end

  // Count to one-hot node select
  always_comb begin
    cfg.sel = '0;
    for (int k = 0; k < kd_pkg::kd_nodes; k++) begin
      cfg.sel[k] = (wr_cnt == kd_pkg::kd_cnt_w'(k));
    end
  end

  assign cfg.wr      = wr_ok;      // Node latches at the same edge
  assign cfg.data    = node_data;  // Data is not registered, write is not pipelined
  assign cfg.loading = load_en;

endmodule

/* hw/kd_node.sv */
// Single internal node; routing is combinational, the level registers sit in kd_tree
`timescale 1ns/1ns

module kd_node (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           wen,          // Select and strobe from the loader
  input  kd_pkg::node_t  wdata,
  input  logic           valid_in,     // A query sits at this node
  input  kd_pkg::patch_t patch,
  output logic           valid_left,   // Toward child 2k+1
  output logic           valid_right   // Toward child 2k+2
);

  kd_pkg::node_t                node_q;    // Stored split word
  logic [kd_pkg::kd_dim_w-1:0]  dim_sel;   // Dimension after folding
  logic [kd_pkg::kd_comp_w-1:0] comp;      // Selected patch component
  logic                         go_left;

  // Node word, zero after reset so everything routes right
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_q <= '0;
    end else if (wen) begin
      node_q <= wdata;
    end
  end

  // Dimensions 5..7 do not exist, treat them as dimension 0
  always_comb begin
    if (node_q.dim < kd_pkg::kd_dims) begin
      dim_sel = node_q.dim;
    end else begin
      dim_sel = '0;
    end
  end

  assign comp    = patch[dim_sel];
  assign go_left = (comp < node_q.median);  // Strictly less, ties go right

  // Exactly one child sees the query
  assign valid_left  = valid_in &  go_left;
  assign valid_right = valid_in & ~go_left;

endmodule

/* hw/kd_tree.sv */
// Fixed-depth pipelined search; one level per clock, result kd_depth clocks after the query edge
`timescale 1ns/1ns

module kd_tree (
  input  logic           clk,
  input  logic           rst_n,
  kd_cfg_if.tree         cfg,
  input  logic           query_valid,
  input  kd_pkg::patch_t query_patch,
  input  kd_pkg::tag_t   query_tag,
  output logic           leaf_valid,
  output kd_pkg::leaf_t  leaf_index,
  output kd_pkg::tag_t   leaf_tag
);

  // Payload pipeline
  // patch_q[l] feeds level l, tag_q[kd_depth] lines up with the leaf vector
  kd_pkg::patch_t patch_q [1:kd_pkg::kd_depth-1];
  kd_pkg::tag_t   tag_q   [1:kd_pkg::kd_depth];

  logic [kd_pkg::kd_leaves-1:0] leaf_vec;  // Registered outputs of the last level

  // No reset, valid bits alone mark live entries
  always_ff @(posedge clk) begin
    patch_q[1] <= query_patch;
    tag_q[1]   <= query_tag;
    for (int i = 2; i < kd_pkg::kd_depth; i++) begin
      patch_q[i] <= patch_q[i-1];
    end
    for (int i = 2; i <= kd_pkg::kd_depth; i++) begin
      tag_q[i] <= tag_q[i-1];
    end
  end

  // One generate block per level
  for (genvar l = 0; l < kd_pkg::kd_depth; l++) begin : g_lvl
    logic [(2**l)-1:0]     v_in;   // Position valids entering this level
    logic [(2**(l+1))-1:0] v_out;  // Node outputs, child positions
    logic [(2**(l+1))-1:0] v_q;    // Registered for the next level
    kd_pkg::patch_t        p_in;

    if (l == 0) begin : g_root
      // Root takes the query straight from the port
      assign v_in = query_valid;
      assign p_in = query_patch;
    end else begin : g_inner
      assign v_in = g_lvl[l-1].v_q;
      assign p_in = patch_q[l];
    end

    // Node index k = 2**l - 1 + j, children land at positions 2j and 2j+1
    for (genvar j = 0; j < 2**l; j++) begin : g_node
      kd_node u_node (
        .clk         (clk),
        .rst_n       (rst_n),
        .wen         (cfg.wr & cfg.sel[(2**l)-1+j]),
        .wdata       (cfg.data),
        .valid_in    (v_in[j]),
        .patch       (p_in),
        .valid_left  (v_out[2*j]),
        .valid_right (v_out[2*j+1])
      );
    end

    // Level register, doubles in width each level
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        v_q <= '0;
      end else begin
        v_q <= v_out;
      end
    end
  end

  assign leaf_vec = g_lvl[kd_pkg::kd_depth-1].v_q;  // Position j is leaf j

  // One-hot to binary
  // OR of set bit positions, fine since at most one bit is live
  always_comb begin
    leaf_index = '0;
    for (int i = 0; i < kd_pkg::kd_leaves; i++) begin
      if (leaf_vec[i]) begin
        leaf_index = leaf_index | kd_pkg::kd_leaf_w'(i);
      end
    end
  end

  assign leaf_valid = |leaf_vec;
  assign leaf_tag   = tag_q[kd_pkg::kd_depth];  // Tag rode along with the patch

endmodule

/* hw/kd_top.sv */
// Top with plain ports; no back-pressure, host must take leaf_valid the cycle it shows up
`timescale 1ns/1ns

module kd_top (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           load_en,      // Load session, level
  input  logic           node_wr,      // Node word strobe
  input  kd_pkg::node_t  node_data,
  input  logic           query_valid,
  input  kd_pkg::patch_t query_patch,
  input  kd_pkg::tag_t   query_tag,
  output logic           leaf_valid,   // kd_depth clocks after query_valid
  output kd_pkg::leaf_t  leaf_index,
  output kd_pkg::tag_t   leaf_tag
);

  kd_cfg_if cfg_if ();  // Loader to node bus

  // Breadth-first address generation
  kd_node_writer u_writer (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_en   (load_en),
    .node_wr   (node_wr),
    .node_data (node_data),
    .cfg       (cfg_if.writer)
  );

  // Search pipeline
  kd_tree u_tree (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg         (cfg_if.tree),
    .query_valid (query_valid),
    .query_patch (query_patch),
    .query_tag   (query_tag),
    .leaf_valid  (leaf_valid),
    .leaf_index  (leaf_index),
    .leaf_tag    (leaf_tag)
  );

endmodule

/* tb/tb_clkgen.sv */
// 100 ns clock from time zero; rst_n released on a falling edge after 4 rising edges
`timescale 1ns/1ns

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  initial clk = 1'b0;
  always #50 clk = ~clk;  // Half period 50 ns

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // Released away from the sampling edge
  end

endmodule

/* tb/kd_monitor.sv */
// Results must arrive in issue order, exactly kd_depth rising edges after the query edge
`timescale 1ns/1ns

module kd_monitor (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          exp_valid,   // Query issued at this edge
  input  kd_pkg::tag_t  exp_tag,
  input  kd_pkg::leaf_t exp_leaf,
  input  logic          leaf_valid,
  input  kd_pkg::leaf_t leaf_index,
  input  kd_pkg::tag_t  leaf_tag,
  output int            errors,
  output int            checked,
  output int            pending      // Results still owed by the DUT
);

  kd_pkg::leaf_t leaf_q [$];  // Expected leaves, oldest first
  kd_pkg::tag_t  tag_q  [$];
  int            issue_q [$]; // Edge number of each issue
  int            cycle;
  int            err_cnt;
  int            chk_cnt;

  always @(posedge clk) begin
    if (!rst_n) begin
      cycle   = 0;
      err_cnt = 0;
      chk_cnt = 0;
    end else begin
      cycle = cycle + 1;
      // Compare first, a query issued this edge is not due yet
      if (leaf_valid) begin
        if (leaf_q.size() == 0) begin
          $display("FAILED %0t: result leaf %0d tag %0d with no query pending",
                   $time, leaf_index, leaf_tag);
          err_cnt++;
        end else begin
          if (leaf_index !== leaf_q[0] || leaf_tag !== tag_q[0]) begin
            $display("FAILED %0t: got leaf %0d tag %0d, expected leaf %0d tag %0d",
                     $time, leaf_index, leaf_tag, leaf_q[0], tag_q[0]);
            err_cnt++;
          end
          if (cycle - issue_q[0] != int'(kd_pkg::kd_depth)) begin
            $display("FAILED %0t: tag %0d took %0d cycles", $time, tag_q[0],
                     cycle - issue_q[0]);
            err_cnt++;
          end
          void'(leaf_q.pop_front());
          void'(tag_q.pop_front());
          void'(issue_q.pop_front());
          chk_cnt++;
        end
      end else if (leaf_q.size() != 0 && cycle - issue_q[0] > int'(kd_pkg::kd_depth)) begin
        $display("FAILED %0t: no result for tag %0d", $time, tag_q[0]);  // Overdue
        err_cnt++;
        void'(leaf_q.pop_front());
        void'(tag_q.pop_front());
        void'(issue_q.pop_front());
      end
      if (exp_valid) begin
        leaf_q.push_back(exp_leaf);
        tag_q.push_back(exp_tag);
        issue_q.push_back(cycle);
      end
    end
  end

  assign errors  = err_cnt;
  assign checked = chk_cnt;
  assign pending = leaf_q.size();

endmodule

/* tb/kd_tree_checker.sv */
// Bound into kd_tree; all properties are off while rst_n is low
`timescale 1ns/1ns

module kd_tree_checker (
  input logic                         clk,
  input logic                         rst_n,
  input logic [kd_pkg::kd_leaves-1:0] leaf_vec,
  input logic                         query_valid,
  input logic                         leaf_valid,
  input logic                         cfg_wr,
  input logic                         cfg_loading
);

  // A query lands in one leaf only
  a_leaf_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(leaf_vec))
    else $error("Leaf vector has more than one bit set");

  // Fixed pipeline latency in both directions
  a_query_to_leaf: assert property (@(posedge clk) disable iff (!rst_n)
    query_valid |-> ##(kd_pkg::kd_depth) leaf_valid)
    else $error("Query produced no leaf after kd_depth cycles");

  a_leaf_from_query: assert property (@(posedge clk) disable iff (!rst_n)
    leaf_valid |-> $past(query_valid, kd_pkg::kd_depth))
    else $error("Leaf valid without a query kd_depth cycles earlier");

  a_wr_in_load: assert property (@(posedge clk) disable iff (!rst_n) cfg_wr |-> cfg_loading)
    else $error("Node write outside a load session");

endmodule

bind kd_tree kd_tree_checker chk0 (
  .clk         (clk),
  .rst_n       (rst_n),
  .leaf_vec    (leaf_vec),
  .query_valid (query_valid),
  .leaf_valid  (leaf_valid),
  .cfg_wr      (cfg.wr),
  .cfg_loading (cfg.loading)
);

/* tb/kd_tb.sv */
// Reads tb/kd_stimulus.txt relative to the project root; inputs change on falling edges only
`timescale 1ns/1ns

module kd_tb;

  localparam int reset_limit = 20;  // Cycles allowed for reset release
  localparam int drain_limit = 40;  // Cycles allowed for results to drain

  logic           clk;
  logic           rst_n;
  logic           load_en;
  logic           node_wr;
  kd_pkg::node_t  node_data;
  logic           query_valid;
  kd_pkg::patch_t query_patch;
  kd_pkg::tag_t   query_tag;
  logic           leaf_valid;
  kd_pkg::leaf_t  leaf_index;
  kd_pkg::tag_t   leaf_tag;
  logic           exp_valid;  // Expected value rides with the query
  kd_pkg::leaf_t  exp_leaf;
  int             mon_errors;
  int             mon_checked;
  int             pending;
  int             timeouts;
  int             file_errors;
  int             queries;

  tb_clkgen clk0 (.clk(clk), .rst_n(rst_n));

  kd_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_en     (load_en),
    .node_wr     (node_wr),
    .node_data   (node_data),
    .query_valid (query_valid),
    .query_patch (query_patch),
    .query_tag   (query_tag),
    .leaf_valid  (leaf_valid),
    .leaf_index  (leaf_index),
    .leaf_tag    (leaf_tag)
  );

  kd_monitor mon0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .exp_valid  (exp_valid),
    .exp_tag    (query_tag),
    .exp_leaf   (exp_leaf),
    .leaf_valid (leaf_valid),
    .leaf_index (leaf_index),
    .leaf_tag   (leaf_tag),
    .errors     (mon_errors),
    .checked    (mon_checked),
    .pending    (pending)
  );

  // Bounded wait until the monitor holds no open query
  task automatic wait_results();
    int n;
    n = 0;
    while (pending != 0 && n < drain_limit) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0) begin
      $display("Timeout at %0t: %0d results never arrived", $time, pending);
      timeouts++;
    end
  endtask

  // One stimulus line takes one falling edge, strobes drop unless renewed
  task automatic apply_line(input string line);
    string cmd;
    int    n;
    int    a0;
    int    a1;
    int    c [kd_pkg::kd_dims];
    int    leaf;
    n = $sscanf(line, "%s", cmd);
    if (n < 1 || cmd.substr(0, 0) == "#") return;  // Blank or comment
    @(negedge clk);
    node_wr     = 1'b0;
    query_valid = 1'b0;
    exp_valid   = 1'b0;
    if (cmd == "L") begin
      load_en = 1'b1;
    end else if (cmd == "E") begin
      load_en = 1'b0;  // Also restarts the write count
    end else if (cmd == "N") begin
      n = $sscanf(line, "%s %d %d", cmd, a0, a1);
      if (n != 3) begin
        $display("Malformed node line in stimulus file: %s", line);
        file_errors++;
      end
      node_wr          = 1'b1;
      node_data.dim    = a0[kd_pkg::kd_dim_w-1:0];
      node_data.median = a1[kd_pkg::kd_comp_w-1:0];
    end else if (cmd == "Q") begin
      n = $sscanf(line, "%s %d %d %d %d %d %d %d", cmd, a0, c[0], c[1], c[2], c[3], c[4],
                  leaf);
      if (n != 8) begin
        $display("Malformed query line in stimulus file: %s", line);
        file_errors++;
      end
      for (int i = 0; i < kd_pkg::kd_dims; i++) begin
        query_patch[i] = c[i][kd_pkg::kd_comp_w-1:0];
      end
      query_tag   = a0[kd_pkg::kd_tag_w-1:0];
      exp_leaf    = leaf[kd_pkg::kd_leaf_w-1:0];
      query_valid = 1'b1;
      exp_valid   = 1'b1;
      queries++;
    end else if (cmd == "D") begin
      wait_results();
    end else begin
      $display("Unknown command in stimulus file: %s", line);
      file_errors++;
    end
  endtask

  initial begin
    int    fd;
    int    n;
    string line;
    load_en     = 1'b0;
    node_wr     = 1'b0;
    node_data   = '0;
    query_valid = 1'b0;
    query_patch = '0;
    query_tag   = '0;
    exp_valid   = 1'b0;
    exp_leaf    = '0;
    timeouts    = 0;
    file_errors = 0;
    queries     = 0;
    n = 0;
    while (rst_n !== 1'b1 && n < reset_limit) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      timeouts++;
    end
    fd = $fopen("tb/kd_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/kd_stimulus.txt");
      file_errors++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) apply_line(line);
      end
      $fclose(fd);
    end
    @(negedge clk);
    node_wr     = 1'b0;
    query_valid = 1'b0;
    exp_valid   = 1'b0;
    wait_results();  // Catch anything after the last D line
    $display("Results %0d of %0d checked, %0d errors, %0d timeouts, %0d file errors",
             mon_checked, queries, mon_errors, timeouts, file_errors);
    if (mon_errors == 0 && timeouts == 0 && file_errors == 0 && mon_checked == queries &&
        queries > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
hw/kd_pkg.sv
hw/kd_cfg_if.sv
hw/kd_node_writer.sv
hw/kd_node.sv
hw/kd_tree.sv
hw/kd_top.sv
tb/tb_clkgen.sv
tb/kd_monitor.sv
tb/kd_tree_checker.sv
tb/kd_tb.sv

/* Makefile */
# Verilator build and run for the KD-tree search testbench

VERILATOR ?= verilator
TOP       ?= kd_tb
FLIST     ?= src.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BUILD)/V%: $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FLIST) --Mdir $(BUILD) -o V$*

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -qx "TEST PASS" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* tb/kd_stimulus.txt */
# Commands: L load_en high, E load_en low, D wait for results, N dim median (node word)
# Q tag c0 c1 c2 c3 c4 expected_leaf (decimal, one query per cycle when lines follow)
# Fresh tree, every node is zero so all queries go right
Q 1 5 6 7 8 9 15
Q 2 2047 0 0 0 0 15
Q 3 0 0 0 0 0 15
D
# First tree, breadth-first, dims 6 and 7 fold to 0
L
N 0 1000
N 1 500
N 2 1500
N 3 200
N 4 700
N 0 1200
N 6 1800
N 1 100
N 2 300
N 3 400
N 4 600
N 0 1100
N 1 900
N 7 1900
N 1 1000
E
# Back-to-back queries, equal components go right
Q 3 0 0 0 0 0 0
Q 4 0 100 0 0 0 1
Q 5 500 100 0 300 0 2
Q 6 999 499 300 450 0 3
Q 7 10 700 0 0 600 4
Q 8 10 700 0 400 5 5
Q 9 500 600 0 0 700 7
Q 10 1050 0 1499 0 0 8
Q 11 1100 0 100 0 0 9
Q 12 1250 0 0 0 0 10
Q 13 1250 900 0 0 0 11
Q 14 1000 0 1500 0 0 12
Q 15 1850 0 1600 0 0 14
Q 0 2047 2047 2047 2047 2047 15
D
# Second tree, plain search on c0, leaf is c0/100 capped at 15
L
N 0 800
N 0 400
N 0 1200
N 0 200
N 0 600
N 0 1000
N 0 1400
N 0 100
N 0 300
N 0 500
N 0 700
N 0 900
N 0 1100
N 0 1300
N 0 1500
# Sixteenth write in the session, must be dropped
N 2 0
E
Q 1 0 2047 2047 2047 2047 0
Q 2 150 0 0 0 0 1
Q 3 300 9 9 9 9 3
Q 4 499 0 0 0 0 4
Q 5 650 0 0 0 0 6
Q 6 799 0 0 0 0 7
Q 7 800 0 0 0 0 8
Q 8 1000 0 0 0 0 10
D
Q 9 1234 0 0 0 0 12
Q 10 1499 0 0 0 0 14
Q 11 1500 0 0 0 0 15
Q 12 1000 0 1500 0 0 10
D
